// ==== Makefile ====
.PHONY: compile run clean

compile: obj_dir/Vtb_lcd

obj_dir/Vtb_lcd: tb.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lcd -f tb.f

run: obj_dir/Vtb_lcd
	./obj_dir/Vtb_lcd > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== lcd_apb_regs.sv ====
// APB3 slave, zero wait states, 4-bit byte offsets
// Only CTRL is writable; writes to STATUS and FRAMES are ignored without error
module lcd_apb_regs
  import lcd_geom_pkg::*, lcd_seq_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        enable,
  input  logic        init_done,
  input  logic        frame_done
);

  frame_cnt_t frame_count;
  logic       access;
  logic       addr_ok;

  assign access  = psel && penable;  // Access phase
  assign addr_ok = paddr inside {REG_CTRL, REG_STATUS, REG_FRAMES};

  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= 1'b0;
    end else if (access && pwrite && paddr == REG_CTRL) begin
      enable <= pwdata[0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      frame_count <= '0;              // Cleared while disabled
    end else if (frame_done) begin
      frame_count <= frame_count + 1'b1;  // Wraps at 2^16
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      REG_CTRL:   prdata = {31'b0, enable};
      REG_STATUS: prdata = {31'b0, init_done};
      REG_FRAMES: prdata = {16'b0, frame_count};
      default:    prdata = '0;
    endcase
  end

  assign pready  = 1'b1;
  assign pslverr = access && !addr_ok;

endmodule

// ==== lcd_asserts.sv ====
// SPI mode 3 and APB protocol checks on the controller pins
// Sampled on clk and idle while reset is high; bound into every lcd_top
module lcd_asserts (
  input logic clk,
  input logic reset,
  input logic spi_csn,
  input logic spi_clk,
  input logic spi_mosi,
  input logic pready
);

  // Clock parks high whenever the panel is deselected
  a_idle_clk_high: assert property (
    @(posedge clk) disable iff (reset) spi_csn |-> spi_clk
  ) else $error("spi_clk is low while spi_csn is high");

  // Data only moves on the falling SPI clock
  a_mosi_stable: assert property (
    @(posedge clk) disable iff (reset) spi_clk |-> $stable(spi_mosi)
  ) else $error("spi_mosi changed while spi_clk was high");

  // Zero wait state slave
  a_pready_high: assert property (
    @(posedge clk) disable iff (reset) pready
  ) else $error("pready is low");

endmodule

bind lcd_top lcd_asserts u_asserts (
  .clk(clk), .reset(reset), .spi_csn(spi_csn), .spi_clk(spi_clk),
  .spi_mosi(spi_mosi), .pready(pready)
);

// ==== lcd_delay_timer.sv ====
// Cycle down-counter shared by reset hold and init pauses
// busy rises the cycle after delay_load; a zero load never goes busy
module lcd_delay_timer
  import lcd_geom_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   delay_load,
  input  delay_t delay_cycles,
  output logic   delay_busy
);

  delay_t count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (delay_load) begin
      count <= delay_cycles;       // Reload wins over countdown
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign delay_busy = (count != '0);  // Drops in the cycle count hits zero

endmodule

// ==== lcd_geom_pkg.sv ====
// Widths of the pixel, coordinate and timing paths
// coord_t covers screens up to 511 pixels on a side
// delay_t holds up to 2^28 clock cycles of reset hold or pause
package lcd_geom_pkg;

  // One SPI byte
  typedef logic [7:0] byte_t;

  // RGB565 pixel, red in the top bits
  typedef logic [15:0] color_t;

  // Raster x or y position
  typedef logic [8:0] coord_t;

  // Reset hold and pause lengths in clk cycles
  typedef logic [27:0] delay_t;

  // Completed frame count, wraps
  typedef logic [15:0] frame_cnt_t;

endpackage

// ==== lcd_init_rom.sv ====
// Fixed ST7789 power-up stream, 32 bytes; INIT_SIZE must match the table
// Window covers 0..X_SIZE-1 and 0..Y_SIZE-1, no offset for panel cut
module lcd_init_rom
  import lcd_geom_pkg::*, lcd_seq_pkg::*;
#(
  parameter int X_SIZE = 240,
  parameter int Y_SIZE = 320,
  parameter int INIT_SIZE = 32,
  localparam int ADDR_W = $clog2(INIT_SIZE + 1)
) (
  input  logic [ADDR_W-1:0] rom_addr,
  output byte_t             rom_data
);

  localparam logic [15:0] X_LAST = 16'(X_SIZE - 1);
  localparam logic [15:0] Y_LAST = 16'(Y_SIZE - 1);

  always_comb begin
    rom_data = LCD_NOP;
    if (rom_addr < INIT_SIZE) begin  // Past the end reads as NOP
      case (rom_addr)
        0:  rom_data = 8'h01;        // SWRESET
        1:  rom_data = 8'h80;        // No args, pause
        2:  rom_data = 8'h07;        // 128 us
        3:  rom_data = 8'h11;        // SLPOUT
        4:  rom_data = 8'h80;
        5:  rom_data = 8'h07;        // 128 us
        6:  rom_data = 8'h3A;        // COLMOD
        7:  rom_data = 8'h01;
        8:  rom_data = 8'h55;        // 16 bit per pixel
        9:  rom_data = 8'h36;        // MADCTL
        10: rom_data = 8'h01;
        11: rom_data = 8'h00;        // Top to bottom, RGB order
        12: rom_data = 8'h21;        // INVON, panel is inverting
        13: rom_data = 8'h00;
        14: rom_data = 8'h13;        // NORON
        15: rom_data = 8'h00;
        16: rom_data = 8'h29;        // DISPON
        17: rom_data = 8'h00;
        18: rom_data = 8'h2A;        // CASET
        19: rom_data = 8'h04;
        20: rom_data = 8'h00;        // Start column 0
        21: rom_data = 8'h00;
        22: rom_data = X_LAST[15:8]; // End column
        23: rom_data = X_LAST[7:0];
        24: rom_data = 8'h2B;        // RASET
        25: rom_data = 8'h04;
        26: rom_data = 8'h00;        // Start row 0
        27: rom_data = 8'h00;
        28: rom_data = Y_LAST[15:8]; // End row
        29: rom_data = Y_LAST[7:0];
        30: rom_data = 8'h2C;        // RAMWR, pixels follow
        31: rom_data = 8'h00;
        default: rom_data = LCD_NOP;
      endcase
    end
  end

endmodule

// ==== lcd_pixel_scan.sv ====
// Raster scanner, high byte of each pixel first
// color must follow x and y combinationally; it is read on the high byte take
// x, y, next_pixel and frame_done update one cycle after the low byte take
module lcd_pixel_scan
  import lcd_geom_pkg::*;
#(
  parameter int X_SIZE = 240,
  parameter int Y_SIZE = 320
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   pix_run,
  input  color_t color,
  output logic   pix_valid,
  output byte_t  pix_byte,
  input  logic   pix_take,
  output coord_t x,
  output coord_t y,
  output logic   next_pixel,
  output logic   frame_done
);

  logic  low_sel;   // Next byte offered is the low half
  byte_t color_lo;
  logic  last_x;
  logic  last_y;

  assign last_x = (x == coord_t'(X_SIZE - 1));
  assign last_y = (y == coord_t'(Y_SIZE - 1));

  always_ff @(posedge clk) begin
    if (pix_take && !low_sel) color_lo <= color[7:0];  // Latch with high byte
  end

  always_ff @(posedge clk) begin
    if (reset || !pix_run) begin
      x          <= '0;   // Parked at origin when stopped
      y          <= '0;
      low_sel    <= 1'b0;
      next_pixel <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      next_pixel <= 1'b0;
      frame_done <= 1'b0;
      if (pix_take) begin
        low_sel <= !low_sel;
        if (low_sel) begin
          next_pixel <= 1'b1;
          if (last_x) begin
            x <= '0;
            if (last_y) begin
              y          <= '0;
              frame_done <= 1'b1;   // Last pixel of the frame
            end else begin
              y <= y + 1'b1;
            end
          end else begin
            x <= x + 1'b1;
          end
        end
      end
    end
  end

  assign pix_valid = pix_run;  // A byte is always ready while running
  assign pix_byte  = low_sel ? color_lo : color[15:8];

endmodule

// ==== lcd_seq_pkg.sv ====
// Init stream layout and register map of the display controller
// Stream entry is cmd, count, nargs arguments, then an exponent byte if the pause flag is set
package lcd_seq_pkg;

  typedef enum logic [2:0] {
    IDLE,         // Panel held in reset
    HOLD_RESET,   // Timed reset pulse
    FETCH_CMD,    // Send command byte
    FETCH_COUNT,  // Decode nargs and pause flag
    SEND_ARGS,    // Send arguments with dc high
    PAUSE,        // Wait 2^n us
    PIXELS        // Continuous RGB565 stream
  } seq_state_t;

  localparam logic [7:0] LCD_NOP = 8'h00;  // Panel no-op command

  localparam int COUNT_DELAY_BIT = 7;  // Pause follows the arguments
  localparam int COUNT_NARGS_LSB = 0;
  localparam int COUNT_NARGS_MSB = 4;  // Up to 31 arguments

  localparam logic [3:0] REG_CTRL   = 4'h0;  // bit 0 enable
  localparam logic [3:0] REG_STATUS = 4'h4;  // bit 0 init done
  localparam logic [3:0] REG_FRAMES = 4'h8;  // Frame counter

endpackage

// ==== lcd_sequencer.sv ====
// Power-up and streaming control for the panel
// CLK_MHZ*RESET_US must be at least 2; two cycles of the hold are FSM overhead
// Dropping enable lets the byte in flight finish, then re-asserts panel reset
module lcd_sequencer
  import lcd_geom_pkg::*, lcd_seq_pkg::*;
#(
  parameter int CLK_MHZ = 25,
  parameter int RESET_US = 150000,
  parameter int INIT_SIZE = 32,
  localparam int ADDR_W = $clog2(INIT_SIZE + 1)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  output logic              init_done,
  output logic              spi_resn,
  output logic [ADDR_W-1:0] rom_addr,
  input  byte_t             rom_data,
  output logic              delay_load,
  output delay_t            delay_cycles,
  input  logic              delay_busy,
  output logic              tx_valid,
  output byte_t             tx_byte,
  output logic              tx_dc,
  input  logic              tx_ready,
  output logic              pix_run,
  input  logic              pix_valid,
  input  byte_t             pix_byte,
  output logic              pix_take
);

  localparam delay_t RESET_HOLD = delay_t'(CLK_MHZ * RESET_US - 2);
  localparam logic [ADDR_W-1:0] ROM_END = ADDR_W'(INIT_SIZE);

  seq_state_t state;
  logic [4:0] nargs;          // Arguments still to send
  logic       pause_pending;
  logic       pause_started;
  logic       accept;

  always_comb begin
    tx_valid = 1'b0;
    tx_byte  = rom_data;
    tx_dc    = 1'b0;
    case (state)
      FETCH_CMD: tx_valid = enable && (rom_addr != ROM_END);
      SEND_ARGS: begin
        tx_valid = enable && (nargs != '0);
        tx_dc    = 1'b1;
      end
      PIXELS: begin
        tx_valid = enable && pix_valid;
        tx_byte  = pix_byte;
        tx_dc    = 1'b1;  // Pixel data
      end
      default: tx_valid = 1'b0;
    endcase
  end

  assign accept   = tx_valid && tx_ready;
  assign pix_run  = (state == PIXELS);
  assign pix_take = accept && (state == PIXELS);

  // Reset hold from IDLE, otherwise pause starts once the shifter is idle
  assign delay_load = ((state == IDLE) && enable)
                   || ((state == PAUSE) && !pause_started && tx_ready);
  assign delay_cycles = (state == IDLE) ? RESET_HOLD
                                        : (delay_t'(CLK_MHZ) << rom_data[4:0]);

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= IDLE;
      rom_addr      <= '0;
      nargs         <= '0;
      pause_pending <= 1'b0;
      pause_started <= 1'b0;
      spi_resn      <= 1'b0;
      init_done     <= 1'b0;
    end else if (state != IDLE && !enable) begin
      if (tx_ready) begin  // Wait out the byte in flight
        state     <= IDLE;
        spi_resn  <= 1'b0;
        init_done <= 1'b0;
      end
    end else begin
      case (state)
        IDLE: begin
          rom_addr      <= '0;
          pause_started <= 1'b0;
          if (enable) state <= HOLD_RESET;
        end
        HOLD_RESET: begin
          if (!delay_busy) begin
            spi_resn <= 1'b1;  // Release panel
            state    <= FETCH_CMD;
          end
        end
        FETCH_CMD: begin
          if (rom_addr == ROM_END) begin
            state     <= PIXELS;
            init_done <= 1'b1;
          end else if (accept) begin
            rom_addr <= rom_addr + 1'b1;
            state    <= FETCH_COUNT;
          end
        end
        FETCH_COUNT: begin
          nargs         <= rom_data[COUNT_NARGS_MSB:COUNT_NARGS_LSB];
          pause_pending <= rom_data[COUNT_DELAY_BIT];
          rom_addr      <= rom_addr + 1'b1;
          state         <= SEND_ARGS;
        end
        SEND_ARGS: begin
          if (nargs == '0) begin
            state <= pause_pending ? PAUSE : FETCH_CMD;
          end else if (accept) begin
            rom_addr <= rom_addr + 1'b1;
            nargs    <= nargs - 5'd1;
          end
        end
        PAUSE: begin
          if (!pause_started) begin
            if (tx_ready) begin  // Timer loaded this cycle from the exponent byte
              pause_started <= 1'b1;
              rom_addr      <= rom_addr + 1'b1;
            end
          end else if (!delay_busy) begin
            pause_started <= 1'b0;
            state         <= FETCH_CMD;
          end
        end
        PIXELS: state <= PIXELS;  // Stream until disabled
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== lcd_spi_shifter.sv ====
// SPI mode 3 byte shifter at clk/2, 16 clk per byte, MSB first
// Accepts a new byte only when idle, so bytes are at least 17 clk apart
module lcd_spi_shifter
  import lcd_geom_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  tx_valid,
  input  byte_t tx_byte,
  input  logic  tx_dc,
  input  logic  hold_cs,
  output logic  tx_ready,
  output logic  spi_csn,
  output logic  spi_clk,
  output logic  spi_mosi,
  output logic  spi_dc
);

  logic       busy;
  logic [3:0] phase;  // Even low, odd high
  byte_t      shreg;
  logic       dc;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      phase <= '0;
      shreg <= '0;
      dc    <= 1'b0;
    end else if (!busy) begin
      if (tx_valid) begin
        busy  <= 1'b1;
        phase <= '0;
        shreg <= tx_byte;  // Bit 7 on MOSI from phase 0
        dc    <= tx_dc;
      end
    end else begin
      phase <= phase + 1'b1;
      if (phase == 4'hF) begin
        busy <= 1'b0;      // Last bit held through the idle gap
      end else if (phase[0]) begin
        shreg <= {shreg[6:0], 1'b0};  // Next bit as clock falls
      end
    end
  end

  assign tx_ready = !busy;
  assign spi_clk  = !busy || phase[0];  // Parked high when idle
  assign spi_csn  = !(busy || hold_cs);
  assign spi_mosi = shreg[7];
  assign spi_dc   = dc;

endmodule

// ==== lcd_testdata.txt ====
// op arg value; 1 write, 2 read and compare, 3 bad offset, 4 SPI byte (arg bit0 dc, bit1 pause)
// 5 pixel frames, 6 pins {resn,csn}, 7 random zero reads, 8 reset hold, 0 end
6 0 1
2 4 0
2 8 0
3 c 0
7 0 6
1 0 1
8 0 0
4 0 01
4 2 11
4 2 3a
4 1 55
4 0 36
4 1 00
4 0 21
4 0 13
4 0 29
4 0 2a
4 1 00
4 1 00
4 1 00
4 1 03
4 0 2b
4 1 00
4 1 00
4 1 00
4 1 02
4 0 2c
2 4 1
5 0 2
2 8 2
1 0 0
2 8 0
6 0 1
0 0 0

// ==== lcd_top.sv ====
// ST7789 SPI display controller with APB control
// No frame buffer; color must follow x and y within the same cycle
module lcd_top
  import lcd_geom_pkg::*;
#(
  parameter int CLK_MHZ = 25,     // clk cycles per microsecond
  parameter int RESET_US = 150000,
  parameter int X_SIZE = 240,
  parameter int Y_SIZE = 320,
  parameter int INIT_SIZE = 32    // Bytes in lcd_init_rom
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output coord_t      x,
  output coord_t      y,
  output logic        next_pixel,
  input  color_t      color,
  output logic        spi_csn,
  output logic        spi_clk,
  output logic        spi_mosi,
  output logic        spi_dc,
  output logic        spi_resn
);

  localparam int ADDR_W = $clog2(INIT_SIZE + 1);

  logic              enable;
  logic              init_done;
  logic              frame_done;
  logic [ADDR_W-1:0] rom_addr;
  byte_t             rom_data;
  logic              delay_load;
  delay_t            delay_cycles;
  logic              delay_busy;
  logic              tx_valid;
  byte_t             tx_byte;
  logic              tx_dc;
  logic              tx_ready;
  logic              pix_run;   // Also holds chip select through the stream
  logic              pix_valid;
  byte_t             pix_byte;
  logic              pix_take;

  lcd_apb_regs u_regs (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .enable(enable), .init_done(init_done), .frame_done(frame_done)
  );

  lcd_sequencer #(
    .CLK_MHZ(CLK_MHZ), .RESET_US(RESET_US), .INIT_SIZE(INIT_SIZE)
  ) u_seq (
    .clk(clk), .reset(reset), .enable(enable), .init_done(init_done),
    .spi_resn(spi_resn), .rom_addr(rom_addr), .rom_data(rom_data),
    .delay_load(delay_load), .delay_cycles(delay_cycles), .delay_busy(delay_busy),
    .tx_valid(tx_valid), .tx_byte(tx_byte), .tx_dc(tx_dc), .tx_ready(tx_ready),
    .pix_run(pix_run), .pix_valid(pix_valid), .pix_byte(pix_byte),
    .pix_take(pix_take)
  );

  lcd_init_rom #(
    .X_SIZE(X_SIZE), .Y_SIZE(Y_SIZE), .INIT_SIZE(INIT_SIZE)
  ) u_rom (
    .rom_addr(rom_addr), .rom_data(rom_data)
  );

  lcd_delay_timer u_timer (
    .clk(clk), .reset(reset), .delay_load(delay_load),
    .delay_cycles(delay_cycles), .delay_busy(delay_busy)
  );

  lcd_spi_shifter u_spi (
    .clk(clk), .reset(reset), .tx_valid(tx_valid), .tx_byte(tx_byte),
    .tx_dc(tx_dc), .hold_cs(pix_run), .tx_ready(tx_ready),
    .spi_csn(spi_csn), .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_dc(spi_dc)
  );

  lcd_pixel_scan #(
    .X_SIZE(X_SIZE), .Y_SIZE(Y_SIZE)
  ) u_scan (
    .clk(clk), .reset(reset), .pix_run(pix_run), .color(color),
    .pix_valid(pix_valid), .pix_byte(pix_byte), .pix_take(pix_take),
    .x(x), .y(y), .next_pixel(next_pixel), .frame_done(frame_done)
  );

endmodule

// ==== tb.f ====
lcd_geom_pkg.sv
lcd_seq_pkg.sv
lcd_init_rom.sv
lcd_delay_timer.sv
lcd_spi_shifter.sv
lcd_pixel_scan.sv
lcd_apb_regs.sv
lcd_sequencer.sv
lcd_top.sv
lcd_asserts.sv
tb_lcd.sv

// ==== tb_lcd.sv ====
// Testbench for lcd_top on a 4x3 screen, 1 MHz clock and 20 us panel reset
// Operations and init bytes come from lcd_testdata.txt, run from the project root
// Colour source is {y, x}, so pixel bytes are the row then the column number
module tb_lcd
  import lcd_geom_pkg::*, lcd_seq_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int CLK_MHZ = 1;
  localparam int RESET_US = 20;
  localparam int X_SIZE = 4;
  localparam int Y_SIZE = 3;
  localparam int RESET_CYCLES = CLK_MHZ * RESET_US;
  localparam int PAUSE_CYCLES = CLK_MHZ * 128;  // 2^7 us after SWRESET and SLPOUT
  localparam int MAX_WORDS = 192;               // Three words per record

  logic        clk = 1'b0;
  logic        reset;
  logic [3:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  coord_t      x;
  coord_t      y;
  logic        next_pixel;
  color_t      color = '0;
  logic        spi_csn;
  logic        spi_clk;
  logic        spi_mosi;
  logic        spi_dc;
  logic        spi_resn;

  logic [31:0] tdata [0:MAX_WORDS-1];  // op, arg, value records
  logic [8:0]  byte_q [$];             // {dc, data} as decoded
  int          gap_q [$];              // Cycles since previous byte
  bit          csn_q [$];              // Chip select rose before byte
  byte_t       shift_in;
  int          nbits = 0;
  bit          csn_rose = 1'b1;        // Deselected out of reset
  time         last_end = 0;
  int          byte_count = 0;
  int          limit_cycles = 0;
  integer      seed = 32'h24ea_0f1e;
  coord_t      prev_x = '0;            // Scan position one cycle earlier
  coord_t      prev_y = '0;

  lcd_top #(
    .CLK_MHZ(CLK_MHZ), .RESET_US(RESET_US), .X_SIZE(X_SIZE), .Y_SIZE(Y_SIZE),
    .INIT_SIZE(32)
  ) DUT (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .x(x), .y(y), .next_pixel(next_pixel), .color(color),
    .spi_csn(spi_csn), .spi_clk(spi_clk), .spi_mosi(spi_mosi), .spi_dc(spi_dc),
    .spi_resn(spi_resn)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(negedge clk) color <= {y[7:0], x[7:0]};  // External colour source

  // SPI decoder, mode 3, MSB first
  always @(posedge spi_clk or posedge spi_csn) begin
    if (spi_csn) begin
      nbits    = 0;
      csn_rose = 1'b1;
    end else begin
      shift_in = {shift_in[6:0], spi_mosi};
      nbits    = nbits + 1;
      if (nbits == 8) begin
        byte_q.push_back({spi_dc, shift_in});
        gap_q.push_back(int'(($time - last_end) / CLK_PERIOD));
        csn_q.push_back(csn_rose);
        last_end = $time;
        csn_rose = 1'b0;
        nbits    = 0;
      end
    end
  end

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  // Raster successor of a position, {x, y}
  function automatic logic [17:0] raster_next(input coord_t px, input coord_t py);
    coord_t nx;
    coord_t ny;
    nx = px;
    ny = py;
    if (px == X_SIZE - 1) begin
      nx = '0;
      ny = (py == Y_SIZE - 1) ? coord_t'(0) : coord_t'(py + 1);  // Wrap to top row
    end else begin
      nx = coord_t'(px + 1);
    end
    return {nx, ny};
  endfunction

  // Position steps once per next_pixel pulse, or parks at the origin when stopped
  always @(negedge clk) begin
    if (!reset) begin
      if (next_pixel) begin
        assert ({x, y} == raster_next(prev_x, prev_y))
          else report_error($sformatf("next_pixel moved %0d,%0d to %0d,%0d",
                                      prev_x, prev_y, x, y));
      end else begin
        assert ({x, y} == {prev_x, prev_y} || {x, y} == '0)
          else report_error($sformatf("x,y moved %0d,%0d to %0d,%0d without next_pixel",
                                      prev_x, prev_y, x, y));
      end
    end
    prev_x = x;
    prev_y = y;
  end

  // One APB transfer, setup then access; outputs sampled mid access cycle
  task automatic apb_access(input bit write, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, '0, rdata, err);
    assert (!err) else report_error($sformatf("pslverr on read of offset %0h", addr));
    assert (rdata == exp)
      else report_error($sformatf("offset %0h reads %0h, expected %0h", addr, rdata, exp));
  endtask

  // Counts falling edges from the CTRL write until the panel leaves reset
  task automatic check_reset_hold();
    int n;
    n = 0;
    while (!spi_resn && n <= RESET_CYCLES + 4) begin
      @(negedge clk);
      n++;
    end
    assert (n == RESET_CYCLES)
      else report_error($sformatf("panel reset held %0d cycles, expected %0d", n, RESET_CYCLES));
  endtask

  task automatic check_pins(input logic [1:0] exp);
    int n;
    n = 0;
    while ({spi_resn, spi_csn} != exp && n < 20) begin  // Byte in flight may finish first
      @(negedge clk);
      n++;
    end
    assert ({spi_resn, spi_csn} == exp)
      else report_error($sformatf("spi_resn=%0b spi_csn=%0b, expected %0b %0b",
                                  spi_resn, spi_csn, exp[1], exp[0]));
  endtask

  task automatic check_spi_byte(input logic [8:0] exp, input bit after_pause, input bit cs_gap);
    logic [8:0] got;
    int         gap;
    bit         cs;
    while (byte_q.size() == 0) @(posedge clk);
    got = byte_q.pop_front();
    gap = gap_q.pop_front();
    cs  = csn_q.pop_front();
    assert (got == exp)
      else report_error($sformatf("SPI byte %0d is dc=%0b %02h, expected dc=%0b %02h",
                                  byte_count, got[8], got[7:0], exp[8], exp[7:0]));
    assert (cs == cs_gap)
      else report_error($sformatf("SPI byte %0d chip select gap %0b, expected %0b",
                                  byte_count, cs, cs_gap));
    if (after_pause) begin
      assert (gap >= PAUSE_CYCLES)
        else report_error($sformatf("SPI byte %0d follows a %0d cycle gap, pause is %0d",
                                    byte_count, gap, PAUSE_CYCLES));
    end
    byte_count++;
  endtask

  // Raster order, high byte is y and low byte is x
  task automatic check_frames(input int frames);
    for (int f = 0; f < frames; f++) begin
      for (int yy = 0; yy < Y_SIZE; yy++) begin
        for (int xx = 0; xx < X_SIZE; xx++) begin
          check_spi_byte({1'b1, 8'(yy)}, 1'b0, 1'b0);
          check_spi_byte({1'b1, 8'(xx)}, 1'b0, 1'b0);
        end
      end
    end
  endtask

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", limit_cycles);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int          pos;
    int          n_bytes;
    int          n_pause;
    logic [31:0] op;
    logic [31:0] arg;
    logic [31:0] val;
    logic [31:0] rdata;
    logic        err;
    logic [3:0]  addr;
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    $readmemh("lcd_testdata.txt", tdata);
    n_bytes = 0;
    n_pause = 0;
    for (int i = 0; i + 2 < MAX_WORDS && tdata[i] != 0; i += 3) begin
      if (tdata[i] == 4) n_bytes++;
      if (tdata[i] == 4 && tdata[i+1][1]) n_pause++;
      if (tdata[i] == 5) n_bytes += tdata[i+2] * X_SIZE * Y_SIZE * 2;
    end
    limit_cycles = RESET_CYCLES + 20 * n_bytes + n_pause * PAUSE_CYCLES + 500;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    pos = 0;
    while (pos + 2 < MAX_WORDS && tdata[pos] != 0) begin
      op  = tdata[pos];
      arg = tdata[pos+1];
      val = tdata[pos+2];
      case (op)
        1: apb_access(1'b1, arg[3:0], val, rdata, err);
        2: read_check(arg[3:0], val);
        3: begin
          apb_access(1'b0, arg[3:0], '0, rdata, err);
          assert (err) else report_error($sformatf("no pslverr at offset %0h", arg[3:0]));
        end
        4: check_spi_byte({arg[0], val[7:0]}, arg[1], 1'b1);  // Init bytes stand alone
        5: check_frames(val);
        6: check_pins(val[1:0]);
        7: begin
          for (int i = 0; i < val; i++) begin
            case ($unsigned($random(seed)) % 3)
              0: addr = REG_CTRL;
              1: addr = REG_STATUS;
              default: addr = REG_FRAMES;
            endcase
            read_check(addr, '0);  // All clear out of reset
          end
        end
        8: check_reset_hold();
        default: report_error($sformatf("unknown operation %0h in data file", op));
      endcase
      pos += 3;
    end
    $display(">>> PASS");
    $finish;
  end

endmodule
